//--- hw/led_pkg.sv
package led_pkg;

  // pwm resolution per colour channel
  localparam int PWM_BITS = 8;

  // pattern memory geometry
  localparam int MEM_DEPTH  = 16;
  localparam int ADDR_BITS  = 4;   // log2 of MEM_DEPTH
  localparam int ENTRY_BITS = 32;  // one packed pattern_entry_t

  // sequencer tick = 2**TICK_DIV_LOG2 clk cycles
  localparam int TICK_DIV_LOG2 = 4;

  // pattern opcodes, top two bits of an entry
  typedef enum logic [1:0] {
    op_set  = 2'd0,  // load colour, then hold
    op_fade = 2'd1,  // step toward colour once per tick, then hold
    op_jump = 2'd2,  // counted jump, red = target, green = repeats
    op_halt = 2'd3   // stop, colour stays
  } opcode_t;

  // sequencer fsm
  typedef enum logic [2:0] {
    st_idle,   // waiting for run
    st_fetch,  // request out on the memory port
    st_wait,   // registered read data arriving
    st_exec,   // decode, fade steps live here too
    st_hold    // counting hold ticks
  } seq_state_t;

  // one program word, msb first
  // bits 31:30 opcode
  // bits 29:24 arg, hold length minus one
  // bits 23:16 red, also jump target (low ADDR_BITS)
  // bits 15:8  green, also jump repeat count
  // bits 7:0   blue
  typedef struct packed {
    opcode_t             opcode;
    logic [5:0]          arg;
    logic [PWM_BITS-1:0] red;
    logic [PWM_BITS-1:0] green;
    logic [PWM_BITS-1:0] blue;
  } pattern_entry_t;

endpackage

//--- hw/mem_if.sv
`timescale 1ns/1ps

// one access port into the pattern memory
// transfer = req_valid & req_ready at a rising edge
// rdata valid in the cycle after the transfer
interface mem_if;

  logic                            req_valid;  // requester wants an access
  logic                            req_ready;  // arbiter grants this cycle
  logic                            we;         // 1 = write, 0 = read
  logic [led_pkg::ADDR_BITS-1:0]   addr;
  logic [led_pkg::ENTRY_BITS-1:0]  wdata;
  logic [led_pkg::ENTRY_BITS-1:0]  rdata;      // registered read data

  // master side, holds addr/we/wdata until ready
  modport requester (
    output req_valid,
    output we,
    output addr,
    output wdata,
    input  req_ready,
    input  rdata
  );

  // memory side
  modport arbiter (
    input  req_valid,
    input  we,
    input  addr,
    input  wdata,
    output req_ready,
    output rdata
  );

endinterface

//--- hw/pattern_mem_arbiter.sv
`timescale 1ns/1ps

module pattern_mem_arbiter (
  input  logic   clk,
  input  logic   arst_n,
  mem_if.arbiter host,  // host write port, low priority
  mem_if.arbiter seq    // sequencer fetch port, high priority
);

  // 16 x 32 pattern store
  logic [led_pkg::ENTRY_BITS-1:0] mem_q [led_pkg::MEM_DEPTH];

  logic                           seq_grant;   // sequencer access this cycle
  logic                           host_grant;  // host access this cycle
  logic                           acc_en;      // any access
  logic                           acc_we;
  logic [led_pkg::ADDR_BITS-1:0]  acc_addr;
  logic [led_pkg::ENTRY_BITS-1:0] acc_wdata;
  logic [led_pkg::ENTRY_BITS-1:0] rd_q;        // shared read register

  // fixed priority
  // sequencer is never stalled, host only gets the idle slots
  assign seq.req_ready  = 1'b1;
  assign host.req_ready = !seq.req_valid;

  assign seq_grant  = seq.req_valid & seq.req_ready;
  assign host_grant = host.req_valid & host.req_ready;  // exclusive with seq_grant
  assign acc_en     = seq_grant | host_grant;

  // steer the winning port onto the single memory port
  always_comb begin
    if (seq_grant) begin
      acc_we    = seq.we;
      acc_addr  = seq.addr;
      acc_wdata = seq.wdata;
    end else begin
      acc_we    = host.we;
      acc_addr  = host.addr;
      acc_wdata = host.wdata;
    end
  end

  // write port of the array
  always_ff @(posedge clk) begin
    if (acc_en && acc_we) begin
      mem_q[acc_addr] <= acc_wdata;  // visible to a fetch from the next edge on
    end
  end

  // registered read, old data on a same-address write
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_q <= '0;
    end else if (acc_en) begin
      rd_q <= mem_q[acc_addr];
    end
  end

  // each port sees the read register in the cycle after its own transfer
  assign seq.rdata  = rd_q;
  assign host.rdata = rd_q;

endmodule

//--- hw/led_sequencer.sv
`timescale 1ns/1ps

module led_sequencer (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         run,     // start pulse, ignored while busy
  mem_if.requester                     mem,     // fetch port, read only
  output logic                         busy,
  output logic [led_pkg::PWM_BITS-1:0] duty_r,
  output logic [led_pkg::PWM_BITS-1:0] duty_g,
  output logic [led_pkg::PWM_BITS-1:0] duty_b
);

  logic [led_pkg::TICK_DIV_LOG2-1:0] presc_q;   // free running prescaler
  logic                              tick;
  led_pkg::seq_state_t               state_q;
  led_pkg::pattern_entry_t           ir_q;      // entry being executed
  logic [led_pkg::ADDR_BITS-1:0]     pc_q;      // address of ir_q
  logic [led_pkg::ADDR_BITS-1:0]     pc_inc;
  logic [led_pkg::ADDR_BITS-1:0]     jmp_tgt;
  logic [5:0]                        hold_q;    // remaining hold ticks minus one
  logic [led_pkg::PWM_BITS-1:0]      rep_q;     // the single repeat counter
  logic [led_pkg::PWM_BITS-1:0]      rep_cur;
  logic                              rep_act_q; // rep_q belongs to jump at rep_pc_q
  logic [led_pkg::ADDR_BITS-1:0]     rep_pc_q;
  logic [led_pkg::PWM_BITS-1:0]      col_r_q, col_g_q, col_b_q;
  logic [led_pkg::PWM_BITS-1:0]      fade_r, fade_g, fade_b;
  logic                              fade_done;

  // one step of a fade toward tgt
  function automatic logic [led_pkg::PWM_BITS-1:0] step_to(
    input logic [led_pkg::PWM_BITS-1:0] cur,
    input logic [led_pkg::PWM_BITS-1:0] tgt
  );
    if (cur < tgt) return cur + 1'b1;
    if (cur > tgt) return cur - 1'b1;
    return cur;
  endfunction

  assign tick    = &presc_q;                            // once per 16 cycles
  assign pc_inc  = pc_q + 1'b1;                         // 15 wraps to 0
  assign jmp_tgt = ir_q.red[led_pkg::ADDR_BITS-1:0];

  assign fade_r    = step_to(col_r_q, ir_q.red);
  assign fade_g    = step_to(col_g_q, ir_q.green);
  assign fade_b    = step_to(col_b_q, ir_q.blue);
  assign fade_done = (fade_r == ir_q.red) && (fade_g == ir_q.green) && (fade_b == ir_q.blue);

  // a jump seen fresh takes its count from green, a repeat uses rep_q
  assign rep_cur = (rep_act_q && rep_pc_q == pc_q) ? rep_q : ir_q.green;

  // fetch port, one read per entry
  assign mem.req_valid = (state_q == led_pkg::st_fetch);
  assign mem.we        = 1'b0;
  assign mem.addr      = pc_q;
  assign mem.wdata     = '0;

  assign busy   = (state_q != led_pkg::st_idle);
  assign duty_r = col_r_q;
  assign duty_g = col_g_q;
  assign duty_b = col_b_q;

  // latch the entry while it sits on rdata
  always_ff @(posedge clk) begin
    if (state_q == led_pkg::st_wait) ir_q <= led_pkg::pattern_entry_t'(mem.rdata);
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      presc_q   <= '0;
      state_q   <= led_pkg::st_idle;
      pc_q      <= '0;
      hold_q    <= '0;
      rep_q     <= '0;
      rep_act_q <= 1'b0;
      rep_pc_q  <= '0;
      col_r_q   <= '0;
      col_g_q   <= '0;
      col_b_q   <= '0;
    end else begin
      presc_q <= presc_q + 1'b1;  // never restarted
      case (state_q)
        led_pkg::st_idle: if (run) begin
          pc_q      <= '0;
          rep_act_q <= 1'b0;
          state_q   <= led_pkg::st_fetch;
        end
        led_pkg::st_fetch: if (mem.req_ready) state_q <= led_pkg::st_wait;
        led_pkg::st_wait:  state_q <= led_pkg::st_exec;
        led_pkg::st_exec: begin
          case (ir_q.opcode)
            led_pkg::op_set: begin
              col_r_q <= ir_q.red;
              col_g_q <= ir_q.green;
              col_b_q <= ir_q.blue;
              hold_q  <= ir_q.arg;
              state_q <= led_pkg::st_hold;
            end
            led_pkg::op_fade: if (tick) begin
              col_r_q <= fade_r;
              col_g_q <= fade_g;
              col_b_q <= fade_b;
              if (fade_done) begin  // target reached on this tick
                hold_q  <= ir_q.arg;
                state_q <= led_pkg::st_hold;
              end
            end
            led_pkg::op_jump: begin
              if (rep_cur != '0) begin
                rep_q     <= rep_cur - 1'b1;
                rep_act_q <= 1'b1;
                rep_pc_q  <= pc_q;
                pc_q      <= jmp_tgt;
              end else begin
                rep_act_q <= 1'b0;  // loop done, next visit is fresh
                pc_q      <= pc_inc;
              end
              state_q <= led_pkg::st_fetch;
            end
            default: state_q <= led_pkg::st_idle;  // halt, colour kept
          endcase
        end
        led_pkg::st_hold: if (tick) begin
          if (hold_q == '0) begin
            pc_q    <= pc_inc;
            state_q <= led_pkg::st_fetch;
          end else begin
            hold_q <= hold_q - 1'b1;
          end
        end
        default: state_q <= led_pkg::st_idle;
      endcase
    end
  end

endmodule

//--- hw/rgb_pwm.sv
`timescale 1ns/1ps

module rgb_pwm (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic [led_pkg::PWM_BITS-1:0] duty_r,
  input  logic [led_pkg::PWM_BITS-1:0] duty_g,
  input  logic [led_pkg::PWM_BITS-1:0] duty_b,
  output logic                         led_r,
  output logic                         led_g,
  output logic                         led_b
);

  logic [led_pkg::PWM_BITS-1:0] cnt_q;        // 256 cycle period
  logic                         wrap;
  logic [led_pkg::PWM_BITS-1:0] duty_in  [3]; // r, g, b
  logic [led_pkg::PWM_BITS-1:0] shadow_q [3]; // duty used this period
  logic [2:0]                   led_q;

  assign duty_in[0] = duty_r;
  assign duty_in[1] = duty_g;
  assign duty_in[2] = duty_b;
  assign wrap       = &cnt_q;  // last count of the period

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt_q <= '0;
      led_q <= '0;
      for (int i = 0; i < 3; i++) shadow_q[i] <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
      for (int i = 0; i < 3; i++) begin
        if (wrap) shadow_q[i] <= duty_in[i];  // new colour only at period start
        led_q[i] <= (cnt_q < shadow_q[i]);   // duty high cycles per period
      end
    end
  end

  assign led_r = led_q[0];
  assign led_g = led_q[1];
  assign led_b = led_q[2];

endmodule

//--- hw/led_pattern_top.sv
`timescale 1ns/1ps

module led_pattern_top (
  input  logic                           clk,
  input  logic                           arst_n,
  // host write port
  input  logic                           wr_valid,
  input  logic [led_pkg::ADDR_BITS-1:0]  wr_addr,
  input  logic [led_pkg::ENTRY_BITS-1:0] wr_data,
  output logic                           wr_ready,  // low while the sequencer fetches
  // control
  input  logic                           run,
  output logic                           busy,
  // pwm outputs
  output logic                           led_r,
  output logic                           led_g,
  output logic                           led_b
);

  mem_if host_mem ();  // host side, write only
  mem_if seq_mem ();   // sequencer fetches

  logic [led_pkg::PWM_BITS-1:0] duty_r, duty_g, duty_b;

  // plain host port onto the bundle
  assign host_mem.req_valid = wr_valid;
  assign host_mem.we        = 1'b1;
  assign host_mem.addr      = wr_addr;
  assign host_mem.wdata     = wr_data;
  assign wr_ready           = host_mem.req_ready;

  pattern_mem_arbiter pattern_mem_arbiter_i (
    .clk    (clk),
    .arst_n (arst_n),
    .host   (host_mem),
    .seq    (seq_mem)
  );

  led_sequencer led_sequencer_i (
    .clk    (clk),
    .arst_n (arst_n),
    .run    (run),
    .mem    (seq_mem),
    .busy   (busy),
    .duty_r (duty_r),
    .duty_g (duty_g),
    .duty_b (duty_b)
  );

  rgb_pwm rgb_pwm_i (
    .clk    (clk),
    .arst_n (arst_n),
    .duty_r (duty_r),
    .duty_g (duty_g),
    .duty_b (duty_b),
    .led_r  (led_r),
    .led_g  (led_g),
    .led_b  (led_b)
  );

endmodule

//--- tb/led_pattern_checker.sv
`timescale 1ns/1ps

// memory port protocol checks, bound into the arbiter
module led_pattern_checker (
  input logic                           clk,
  input logic                           arst_n,
  input logic                           seq_valid,
  input logic                           seq_ready,
  input logic                           host_valid,
  input logic                           host_ready,
  input logic [led_pkg::ADDR_BITS-1:0]  host_addr,
  input logic [led_pkg::ENTRY_BITS-1:0] host_wdata
);

  // single memory port, never two accesses in one cycle
  one_grant: assert property (@(posedge clk) disable iff (!arst_n)
    !(seq_valid && seq_ready && host_valid && host_ready))
    else $error("both memory ports granted in the same cycle");

  // stalled host write keeps its request stable
  host_stable: assert property (@(posedge clk) disable iff (!arst_n)
    (host_valid && !host_ready) |=> (host_valid && $stable(host_addr) && $stable(host_wdata)))
    else $error("host request changed while waiting for ready");

  host_granted: assert property (@(posedge clk) disable iff (!arst_n)
    host_valid |-> ##[0:4] host_ready)  // fetches are at least 3 cycles apart
    else $error("host write not granted in time");

endmodule

bind pattern_mem_arbiter led_pattern_checker led_pattern_checker_i (
  .clk        (clk),
  .arst_n     (arst_n),
  .seq_valid  (seq.req_valid),
  .seq_ready  (seq.req_ready),
  .host_valid (host.req_valid),
  .host_ready (host.req_ready),
  .host_addr  (host.addr),
  .host_wdata (host.wdata)
);

//--- tb/led_pattern_tb.sv
`timescale 1ns/1ps

module led_pattern_tb;

  logic        clk;
  logic        arst_n;
  logic        wr_valid;
  logic [3:0]  wr_addr;
  logic [31:0] wr_data;
  logic        wr_ready;
  logic        run;
  logic        busy;
  logic        led_r, led_g, led_b;

  logic [31:0] prog [16];       // image of what the host wrote
  logic [7:0]  mdl_r, mdl_g, mdl_b;  // model colour, persists across runs
  logic [31:0] lfsr_q = 32'h5cbaab5c;
  int          errors = 0;
  int          bound_sum = 0;   // model cycles so far, feeds the watchdog
  int          last_wait;       // cycles the last write waited for ready
  int          n_tests = 0;
  int          n_bad = 0;

  led_pattern_top led_pattern_top_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .wr_valid (wr_valid),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .wr_ready (wr_ready),
    .run      (run),
    .busy     (busy),
    .led_r    (led_r),
    .led_g    (led_g),
    .led_b    (led_b)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] make_entry(input led_pkg::opcode_t op, input logic [5:0] arg,
                                             input logic [7:0] r, g, b);
    led_pkg::pattern_entry_t e;
    e.opcode = op;
    e.arg    = arg;
    e.red    = r;
    e.green  = g;
    e.blue   = b;
    return e;
  endfunction

  // set or fade, short hold
  function automatic logic [31:0] rand_body();
    led_pkg::opcode_t op;
    op = (rand_bits(2) == 0) ? led_pkg::op_fade : led_pkg::op_set;
    return make_entry(op, rand_bits(2), rand_bits(8), rand_bits(8), rand_bits(8));
  endfunction

  function automatic int chan_dist(input logic [7:0] a, input logic [7:0] b);
    return (a > b) ? a - b : b - a;
  endfunction

  // walks the program image by the opcode rules, returns hold and fade ticks
  task automatic model_run(output int ticks);
    led_pkg::pattern_entry_t e;
    int pc, steps, cnt, rep_pc, rep_cnt, d;
    logic rep_act;
    pc = 0;
    ticks = 0;
    rep_act = 1'b0;
    for (steps = 0; steps < 10000; steps++) begin
      e = prog[pc];
      case (e.opcode)
        led_pkg::op_set: begin
          {mdl_r, mdl_g, mdl_b} = {e.red, e.green, e.blue};
          ticks += e.arg + 1;
          pc = (pc + 1) % 16;
        end
        led_pkg::op_fade: begin
          d = chan_dist(mdl_r, e.red);
          if (chan_dist(mdl_g, e.green) > d) d = chan_dist(mdl_g, e.green);
          if (chan_dist(mdl_b, e.blue) > d) d = chan_dist(mdl_b, e.blue);
          ticks += ((d == 0) ? 1 : d) + e.arg + 1;  // already there still costs a tick
          {mdl_r, mdl_g, mdl_b} = {e.red, e.green, e.blue};
          pc = (pc + 1) % 16;
        end
        led_pkg::op_jump: begin
          cnt = (rep_act && rep_pc == pc) ? rep_cnt : e.green;  // fresh jump loads green
          if (cnt != 0) begin
            rep_cnt = cnt - 1;
            rep_act = 1'b1;
            rep_pc  = pc;
            pc      = e.red[3:0];
          end else begin
            rep_act = 1'b0;
            pc      = (pc + 1) % 16;
          end
        end
        default: return;  // halt
      endcase
    end
    $display("model error: program never reaches a halt entry");
    errors++;
  endtask

  task automatic write_entry(input int addr, input logic [31:0] data);
    @(negedge clk);
    wr_valid  = 1'b1;
    wr_addr   = addr[3:0];
    wr_data   = data;
    last_wait = 0;
    while (!wr_ready) begin  // sequencer fetch has the port
      @(negedge clk);
      last_wait++;
    end
    @(negedge clk);  // transfer on the edge in between
    wr_valid   = 1'b0;
    prog[addr] = data;
  endtask

  // pulse run, count cycles until busy drops
  task automatic run_prog(output int cyc);
    @(negedge clk);
    run = 1'b1;
    @(negedge clk);
    run = 1'b0;
    assert (busy) else begin
      $display("FAILED %0t busy expected 1 got %0b", $time, busy);
      errors++;
    end
    cyc = 1;
    while (busy) begin
      @(negedge clk);
      cyc++;
    end
  endtask

  task automatic check_bound(input int cyc, input int ticks);
    // first tick of the run may land after 1 cycle
    assert (cyc >= ticks * 16 - 15) else begin
      $display("FAILED %0t busy cycles expected >= %0d got %0d", $time, ticks * 16 - 15, cyc);
      errors++;
    end
  endtask

  // high cycles per 256 window vs model colour
  task automatic check_leds();
    int cr, cg, cb;
    cr = 0;
    cg = 0;
    cb = 0;
    repeat (512) @(negedge clk);  // colour settled at least a full period ago
    repeat (256) begin
      @(negedge clk);
      cr += led_r;
      cg += led_g;
      cb += led_b;
    end
    assert (cr == mdl_r) else begin
      $display("FAILED %0t led_r high count expected %0d got %0d", $time, mdl_r, cr);
      errors++;
    end
    assert (cg == mdl_g) else begin
      $display("FAILED %0t led_g high count expected %0d got %0d", $time, mdl_g, cg);
      errors++;
    end
    assert (cb == mdl_b) else begin
      $display("FAILED %0t led_b high count expected %0d got %0d", $time, mdl_b, cb);
      errors++;
    end
  endtask

  task automatic run_and_check();
    int ticks, cyc;
    model_run(ticks);
    bound_sum += ticks * 16;
    run_prog(cyc);
    check_bound(cyc, ticks);
    check_leds();
  endtask

  task automatic end_test(input string name, input int errs0);
    n_tests++;
    if (errors != errs0) n_bad++;
    $display("%s: %0d errors", name, errors - errs0);
  endtask

  // hang guard, budget grows with each modelled run
  initial begin : watchdog
    int cyc;
    cyc = 0;
    while (cyc <= bound_sum * 4 + 100000) begin
      @(posedge clk);
      cyc++;
    end
    $display("timeout: simulation still running after %0d cycles", cyc);
    $display("Test failed");
    $finish;
  end

  initial begin : main
    int ticks, cyc, errs0, n_body;
    logic [7:0] r, g, b;
    arst_n   = 1'b0;
    wr_valid = 1'b0;
    wr_addr  = '0;
    wr_data  = '0;
    run      = 1'b0;
    repeat (8) @(negedge clk);
    arst_n = 1'b1;

    // reset state
    errs0 = errors;
    assert (!busy && !led_r && !led_g && !led_b && wr_ready) else begin
      $display("FAILED %0t busy/leds/wr_ready expected 0/000/1 got %0b/%0b%0b%0b/%0b",
               $time, busy, led_r, led_g, led_b, wr_ready);
      errors++;
    end
    {mdl_r, mdl_g, mdl_b} = '0;
    check_leds();  // stays dark
    end_test("reset_state", errs0);

    // set then halt, duty extremes in the first two rounds
    errs0 = errors;
    for (int k = 0; k < 3; k++) begin
      r = rand_bits(8);
      g = rand_bits(8);
      b = rand_bits(8);
      if (k == 0) {r, g} = {8'd0, 8'd255};
      if (k == 1) {r, b} = {8'd255, 8'd0};
      write_entry(0, make_entry(led_pkg::op_set, rand_bits(2), r, g, b));
      write_entry(1, make_entry(led_pkg::op_halt, 0, 0, 0, 0));
      run_and_check();
    end
    end_test("set_halt", errs0);

    errs0 = errors;
    write_entry(0, make_entry(led_pkg::op_set, 0, rand_bits(8), rand_bits(8), rand_bits(8)));
    write_entry(1, make_entry(led_pkg::op_fade, rand_bits(2), rand_bits(8), rand_bits(8),
                              rand_bits(8)));
    write_entry(2, make_entry(led_pkg::op_halt, 0, 0, 0, 0));
    run_and_check();
    end_test("fade", errs0);

    // counted loop back over the two sets
    errs0 = errors;
    write_entry(0, make_entry(led_pkg::op_set, rand_bits(2), rand_bits(8), rand_bits(8), 8'd0));
    write_entry(1, make_entry(led_pkg::op_set, rand_bits(2), rand_bits(8), 8'd0, rand_bits(8)));
    write_entry(2, make_entry(led_pkg::op_jump, 0, rand_bits(1), rand_bits(3), 0));
    write_entry(3, make_entry(led_pkg::op_set, 0, rand_bits(8), rand_bits(8), rand_bits(8)));
    write_entry(4, make_entry(led_pkg::op_halt, 0, 0, 0, 0));
    run_and_check();
    end_test("jump_repeat", errs0);

    // host writes behind the halt while short steps keep fetching
    errs0 = errors;
    write_entry(0, make_entry(led_pkg::op_set, 0, rand_bits(8), rand_bits(8), rand_bits(8)));
    write_entry(1, make_entry(led_pkg::op_set, 0, rand_bits(8), rand_bits(8), rand_bits(8)));
    write_entry(2, make_entry(led_pkg::op_jump, 0, 0, 15, 0));
    write_entry(3, make_entry(led_pkg::op_halt, 0, 0, 0, 0));
    model_run(ticks);
    bound_sum += ticks * 16;
    fork
      run_prog(cyc);
      begin
        repeat (3) @(negedge clk);
        for (int a = 4; a < 16; a++) begin
          repeat (rand_bits(2)) @(negedge clk);
          write_entry(a, (a == 15) ? make_entry(led_pkg::op_halt, 0, 0, 0, 0) : rand_body());
          assert (last_wait < 4) else begin
            $display("FAILED %0t wr_ready wait cycles expected < 4 got %0d", $time, last_wait);
            errors++;
          end
        end
      end
    join
    check_bound(cyc, ticks);
    check_leds();
    write_entry(0, make_entry(led_pkg::op_jump, 0, 8'd4, 8'd1, 0));  // into the new entries
    run_and_check();
    end_test("write_contention", errs0);

    // random legal programs, one backward jump each
    errs0 = errors;
    for (int p = 0; p < 20; p++) begin
      n_body = 2 + rand_bits(3);
      for (int a = 0; a < n_body; a++) write_entry(a, rand_body());
      write_entry(n_body, make_entry(led_pkg::op_jump, 0, rand_bits(4) % n_body, rand_bits(2), 0));
      write_entry(n_body + 1, make_entry(led_pkg::op_halt, 0, 0, 0, 0));
      run_and_check();
    end
    end_test("random_programs", errs0);

    $display("tests run %0d, tests with errors %0d, failed checks %0d", n_tests, n_bad, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- compile.f
hw/led_pkg.sv
hw/mem_if.sv
hw/pattern_mem_arbiter.sv
hw/led_sequencer.sv
hw/rgb_pwm.sv
hw/led_pattern_top.sv
tb/led_pattern_checker.sv
tb/led_pattern_tb.sv
